//--- verilog/backend_pkg.sv
// shared sizes, opcode enums and packets; one mult and one branch unit, unit index is 1 bit wide
`default_nettype none

package backend_pkg;

    // datapath and register file sizes
    localparam int xlen = 32;
    localparam int phys_reg_idx_w = 6;
    localparam int num_phys_regs = 1 << phys_reg_idx_w;
    localparam logic [phys_reg_idx_w-1:0] zero_reg = '0;

    // reorder buffer tag and unit index within a class
    localparam int rob_idx_w = 5;
    localparam int fu_idx_w = 1;

    // only the alu count is a module parameter
    localparam int num_fu_mult = 1;
    localparam int num_fu_branch = 1;

    typedef enum logic [1:0] {
        fu_alu    = 2'd0,
        fu_mult   = 2'd1,
        fu_branch = 2'd2
    } fu_class_e;

    // alu opcodes, prefixed since and/or/xor are keywords
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_func_e;

    typedef enum logic [2:0] {
        br_beq  = 3'd0,
        br_bne  = 3'd1,
        br_blt  = 3'd2,
        br_bge  = 3'd3,
        br_bltu = 3'd4,
        br_bgeu = 3'd5,
        br_jal  = 3'd6
    } br_func_e;

    // one instruction from the issuer, operands already read
    typedef struct packed {
        logic                      valid;
        fu_class_e                 fu_class;
        logic [fu_idx_w-1:0]       fu_index;
        alu_func_e                 alu_func;
        br_func_e                  br_func;
        logic [xlen-1:0]           pc;
        logic [xlen-1:0]           rs1_value;
        logic [xlen-1:0]           rs2_value;
        logic [xlen-1:0]           imm;
        logic [phys_reg_idx_w-1:0] dest_reg_idx;
        logic [rob_idx_w-1:0]      rob_index;
    } issue_packet_t;

    // finished result, held in a unit and then in the execute/complete register
    typedef struct packed {
        logic                      valid;
        fu_class_e                 fu_class;
        logic [fu_idx_w-1:0]       fu_index;
        logic [xlen-1:0]           pc;
        logic [xlen-1:0]           npc;
        logic [xlen-1:0]           result;
        logic                      take_branch;
        logic [phys_reg_idx_w-1:0] dest_reg_idx;
        logic [rob_idx_w-1:0]      rob_index;
    } ex_co_packet_t;

    typedef struct packed {
        logic                 valid;
        logic [rob_idx_w-1:0] rob_index;
        logic                 take_branch;
        logic [xlen-1:0]      branch_target;
        fu_class_e            fu_class;
    } co_rob_packet_t;

    // common data bus write
    typedef struct packed {
        logic                      en;
        logic [phys_reg_idx_w-1:0] idx;
        logic [xlen-1:0]           data;
    } cdb_t;

endpackage

`default_nettype wire

//--- verilog/alu_unit.sv
// single-cycle alu; always uses rs2_value as operand b, start must only come while idle
`default_nettype none

module alu_unit import backend_pkg::*; (
    input  logic          clock,
    input  logic          arst_n,
    input  logic          start,
    input  issue_packet_t in_packet,
    input  logic          taken,
    output logic          done,
    output ex_co_packet_t out_packet
);

    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    logic [4:0]      shamt;
    logic [xlen-1:0] alu_out;
    ex_co_packet_t   next_pkt;
    ex_co_packet_t   res_q;

    assign opa   = in_packet.rs1_value;
    assign opb   = in_packet.rs2_value;
    // shifts only look at the low 5 bits
    assign shamt = opb[4:0];

    always_comb begin
        case (in_packet.alu_func)
            alu_add:  alu_out = opa + opb;
            alu_sub:  alu_out = opa - opb;
            alu_and:  alu_out = opa & opb;
            alu_or:   alu_out = opa | opb;
            alu_xor:  alu_out = opa ^ opb;
            alu_sll:  alu_out = opa << shamt;
            alu_srl:  alu_out = opa >> shamt;
            alu_sra:  alu_out = $signed(opa) >>> shamt;
            alu_slt:  alu_out = xlen'($signed(opa) < $signed(opb));
            alu_sltu: alu_out = xlen'(opa < opb);
            default:  alu_out = '0;
        endcase
    end

    // result packet, sequential npc and no redirect
    always_comb begin
        next_pkt              = '0;
        next_pkt.valid        = 1'b1;
        next_pkt.fu_class     = in_packet.fu_class;
        next_pkt.fu_index     = in_packet.fu_index;
        next_pkt.pc           = in_packet.pc;
        next_pkt.npc          = in_packet.pc + xlen'(4);
        next_pkt.result       = alu_out;
        next_pkt.dest_reg_idx = in_packet.dest_reg_idx;
        next_pkt.rob_index    = in_packet.rob_index;
    end

    // busy flag, set on issue and dropped once the selector takes it
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b1;
        end else if (taken) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            res_q <= next_pkt;
        end
    end

    always_comb begin
        out_packet       = res_q;
        out_packet.valid = done;
    end

endmodule

`default_nettype wire

//--- verilog/branch_unit.sv
// resolves one branch or jal per issue; target is pc plus imm, link is pc plus 4
`default_nettype none

module branch_unit import backend_pkg::*; (
    input  logic          clock,
    input  logic          arst_n,
    input  logic          start,
    input  issue_packet_t in_packet,
    input  logic          taken,
    output logic          done,
    output ex_co_packet_t out_packet
);

    logic          take;
    ex_co_packet_t next_pkt;
    ex_co_packet_t res_q;

    always_comb begin
        case (in_packet.br_func)
            br_beq:  take = in_packet.rs1_value == in_packet.rs2_value;
            br_bne:  take = in_packet.rs1_value != in_packet.rs2_value;
            br_blt:  take = $signed(in_packet.rs1_value) < $signed(in_packet.rs2_value);
            br_bge:  take = $signed(in_packet.rs1_value) >= $signed(in_packet.rs2_value);
            br_bltu: take = in_packet.rs1_value < in_packet.rs2_value;
            br_bgeu: take = in_packet.rs1_value >= in_packet.rs2_value;
            // jal is unconditional
            br_jal:  take = 1'b1;
            default: take = 1'b0;
        endcase
    end

    // result carries the target, npc the link written back when taken
    always_comb begin
        next_pkt              = '0;
        next_pkt.valid        = 1'b1;
        next_pkt.fu_class     = in_packet.fu_class;
        next_pkt.fu_index     = in_packet.fu_index;
        next_pkt.pc           = in_packet.pc;
        next_pkt.npc          = in_packet.pc + xlen'(4);
        next_pkt.result       = in_packet.pc + in_packet.imm;
        next_pkt.take_branch  = take;
        next_pkt.dest_reg_idx = in_packet.dest_reg_idx;
        next_pkt.rob_index    = in_packet.rob_index;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b1;
        end else if (taken) begin
            done <= 1'b0;
        end
    end

    // payload holds until the selector takes it
    always_ff @(posedge clock) begin
        if (start) begin
            res_q <= next_pkt;
        end
    end

    always_comb begin
        out_packet       = res_q;
        out_packet.valid = done;
    end

endmodule

`default_nettype wire

//--- verilog/mult_unit.sv
// low 32 bits of rs1 times rs2 over num_mult_stages stages (1 to 8); last stage holds until taken
`default_nettype none

module mult_unit import backend_pkg::*; #(
    parameter int num_mult_stages = 4
) (
    input  logic          clock,
    input  logic          arst_n,
    input  logic          start,
    input  issue_packet_t in_packet,
    input  logic          taken,
    output logic          done,
    output ex_co_packet_t out_packet
);

    localparam int last = num_mult_stages - 1;

    ex_co_packet_t first_pkt;
    ex_co_packet_t stage_pkt [num_mult_stages];
    logic          stage_valid [num_mult_stages];

    // product formed up front, later stages only carry it
    always_comb begin
        first_pkt              = '0;
        first_pkt.valid        = 1'b1;
        first_pkt.fu_class     = in_packet.fu_class;
        first_pkt.fu_index     = in_packet.fu_index;
        first_pkt.pc           = in_packet.pc;
        first_pkt.npc          = in_packet.pc + xlen'(4);
        first_pkt.result       = in_packet.rs1_value * in_packet.rs2_value;
        first_pkt.dest_reg_idx = in_packet.dest_reg_idx;
        first_pkt.rob_index    = in_packet.rob_index;
    end

    for (genvar i = 0; i < num_mult_stages; i++) begin : g_stage
        ex_co_packet_t in_pkt;
        logic          in_valid;

        if (i == 0) begin : g_head
            assign in_valid = start;
            assign in_pkt   = first_pkt;
        end else begin : g_body
            assign in_valid = stage_valid[i-1];
            assign in_pkt   = stage_pkt[i-1];
        end

        if (i == last) begin : g_hold
            // output stage keeps done high until the selector takes it
            always_ff @(posedge clock or negedge arst_n) begin
                if (!arst_n) begin
                    stage_valid[i] <= 1'b0;
                end else if (in_valid) begin
                    stage_valid[i] <= 1'b1;
                end else if (taken) begin
                    stage_valid[i] <= 1'b0;
                end
            end
        end else begin : g_pipe
            // inner stages advance every cycle
            always_ff @(posedge clock or negedge arst_n) begin
                if (!arst_n) begin
                    stage_valid[i] <= 1'b0;
                end else begin
                    stage_valid[i] <= in_valid;
                end
            end
        end

        always_ff @(posedge clock) begin
            if (in_valid) begin
                stage_pkt[i] <= in_pkt;
            end
        end
    end

    assign done = stage_valid[last];

    always_comb begin
        out_packet       = stage_pkt[last];
        out_packet.valid = done;
    end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
// routes each issue to its unit with no back-pressure; issuer must target idle units only
`default_nettype none

module execute_stage import backend_pkg::*; #(
    parameter int num_fu_alu      = 2,
    parameter int num_mult_stages = 4
) (
    input  logic          clock,
    input  logic          arst_n,
    input  logic          issue_valid,
    input  issue_packet_t issue_packet,
    output ex_co_packet_t ex_co_reg
);

    logic [num_fu_alu-1:0] alu_start;
    logic [num_fu_alu-1:0] alu_done;
    logic [num_fu_alu-1:0] alu_taken;
    ex_co_packet_t         alu_pkt [num_fu_alu];

    logic          mult_start;
    logic          mult_done;
    logic          mult_taken;
    ex_co_packet_t mult_pkt;

    logic          branch_start;
    logic          branch_done;
    logic          branch_taken;
    ex_co_packet_t branch_pkt;

    ex_co_packet_t sel_pkt;

    // issue decode by class and index
    assign mult_start   = issue_valid && (issue_packet.fu_class == fu_mult);
    assign branch_start = issue_valid && (issue_packet.fu_class == fu_branch);

    for (genvar k = 0; k < num_fu_alu; k++) begin : g_alu
        assign alu_start[k] = issue_valid && (issue_packet.fu_class == fu_alu)
                              && (issue_packet.fu_index == fu_idx_w'(k));

        alu_unit u_alu (
            .clock      (clock),
            .arst_n     (arst_n),
            .start      (alu_start[k]),
            .in_packet  (issue_packet),
            .taken      (alu_taken[k]),
            .done       (alu_done[k]),
            .out_packet (alu_pkt[k])
        );
    end

    mult_unit #(
        .num_mult_stages (num_mult_stages)
    ) u_mult (
        .clock      (clock),
        .arst_n     (arst_n),
        .start      (mult_start),
        .in_packet  (issue_packet),
        .taken      (mult_taken),
        .done       (mult_done),
        .out_packet (mult_pkt)
    );

    branch_unit u_branch (
        .clock      (clock),
        .arst_n     (arst_n),
        .start      (branch_start),
        .in_packet  (issue_packet),
        .taken      (branch_taken),
        .done       (branch_done),
        .out_packet (branch_pkt)
    );

    // fixed priority: mult, branch, then alus from index 0 up
    always_comb begin
        sel_pkt      = '0;
        mult_taken   = 1'b0;
        branch_taken = 1'b0;
        alu_taken    = '0;
        if (mult_done) begin
            sel_pkt    = mult_pkt;
            mult_taken = 1'b1;
        end else if (branch_done) begin
            sel_pkt      = branch_pkt;
            branch_taken = 1'b1;
        end else begin
            // scan downward so the lowest done index wins
            for (int k = num_fu_alu - 1; k >= 0; k--) begin
                if (alu_done[k]) begin
                    sel_pkt      = alu_pkt[k];
                    alu_taken    = '0;
                    alu_taken[k] = 1'b1;
                end
            end
        end
    end

    // losing units keep their hold registers for a later cycle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ex_co_reg <= '0;
        end else begin
            ex_co_reg <= sel_pkt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/complete_stage.sv
// purely combinational; frees the unit on every valid packet, halt handling is left to the rob
`default_nettype none

module complete_stage import backend_pkg::*; #(
    parameter int num_fu_alu = 2
) (
    input  ex_co_packet_t           ex_co_reg,
    output cdb_t                    cdb,
    output co_rob_packet_t          co_rob_packet,
    output logic [num_fu_alu-1:0]    free_alu,
    output logic [num_fu_mult-1:0]   free_mult,
    output logic [num_fu_branch-1:0] free_branch
);

    logic is_branch;

    assign is_branch = ex_co_reg.fu_class == fu_branch;

    // register write, skipped for the zero register
    assign cdb.en  = ex_co_reg.valid && (ex_co_reg.dest_reg_idx != zero_reg);
    assign cdb.idx = ex_co_reg.dest_reg_idx;
    // taken branch writes the link, everything else its result
    assign cdb.data = ex_co_reg.take_branch ? ex_co_reg.npc : ex_co_reg.result;

    // rob completion, target only means something for branches
    assign co_rob_packet.valid         = ex_co_reg.valid;
    assign co_rob_packet.rob_index     = ex_co_reg.rob_index;
    assign co_rob_packet.take_branch   = ex_co_reg.take_branch;
    assign co_rob_packet.branch_target = is_branch ? ex_co_reg.result : ex_co_reg.npc;
    assign co_rob_packet.fu_class      = ex_co_reg.fu_class;

    // one-hot free pulse for the unit that just finished
    always_comb begin
        free_alu    = '0;
        free_mult   = '0;
        free_branch = '0;
        if (ex_co_reg.valid) begin
            case (ex_co_reg.fu_class)
                fu_alu: begin
                    free_alu[ex_co_reg.fu_index] = 1'b1;
                end
                fu_mult: begin
                    free_mult[ex_co_reg.fu_index] = 1'b1;
                end
                fu_branch: begin
                    free_branch[ex_co_reg.fu_index] = 1'b1;
                end
                default: begin
                    free_alu = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/phys_regfile.sv
// 64 x 32 register file; cdb write lands on the next edge, read is combinational
`default_nettype none

module phys_regfile import backend_pkg::*; (
    input  logic                      clock,
    input  logic                      arst_n,
    input  cdb_t                      cdb,
    input  logic [phys_reg_idx_w-1:0] rf_read_idx,
    output logic [xlen-1:0]           rf_read_data
);

    logic [xlen-1:0] regs [num_phys_regs];

    // whole array clears on reset so reads are defined from the start
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < num_phys_regs; r++) begin
                regs[r] <= '0;
            end
        end else if (cdb.en && (cdb.idx != zero_reg)) begin
            regs[cdb.idx] <= cdb.data;
        end
    end

    // no bypass, a same-cycle write is seen one cycle later
    assign rf_read_data = (rf_read_idx == zero_reg) ? '0 : regs[rf_read_idx];

endmodule

`default_nettype wire

//--- verilog/backend_top.sv
// execute through complete; num_fu_alu at most 2 and num_mult_stages 1 to 8
`default_nettype none

module backend_top import backend_pkg::*; #(
    parameter int num_fu_alu      = 2,
    parameter int num_mult_stages = 4
) (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      issue_valid,
    input  issue_packet_t             issue_packet,
    input  logic [phys_reg_idx_w-1:0] rf_read_idx,
    output cdb_t                      cdb,
    output co_rob_packet_t            co_rob_packet,
    output logic [num_fu_alu-1:0]     free_alu,
    output logic [num_fu_mult-1:0]    free_mult,
    output logic [num_fu_branch-1:0]  free_branch,
    output logic [xlen-1:0]           rf_read_data
);

    ex_co_packet_t ex_co_reg;

    execute_stage #(
        .num_fu_alu      (num_fu_alu),
        .num_mult_stages (num_mult_stages)
    ) u_execute (
        .clock        (clock),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .issue_packet (issue_packet),
        .ex_co_reg    (ex_co_reg)
    );

    complete_stage #(
        .num_fu_alu (num_fu_alu)
    ) u_complete (
        .ex_co_reg     (ex_co_reg),
        .cdb           (cdb),
        .co_rob_packet (co_rob_packet),
        .free_alu      (free_alu),
        .free_mult     (free_mult),
        .free_branch   (free_branch)
    );

    // cdb also feeds the register file
    phys_regfile u_regfile (
        .clock        (clock),
        .arst_n       (arst_n),
        .cdb          (cdb),
        .rf_read_idx  (rf_read_idx),
        .rf_read_data (rf_read_data)
    );

endmodule

`default_nettype wire

//--- test/backend_tb.sv
// random issue into 2 alus, mult and branch; only idle units are targeted, 400 instructions
`default_nettype none

module backend_tb import backend_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_fu_alu      = 2;
    localparam int num_mult_stages = 4;
    localparam int reset_cycles    = 16;
    localparam int num_instr       = 400;
    // issue phase, then the register sweep and a little slack
    localparam int watchdog_cycles = reset_cycles + num_instr * (num_mult_stages + 8)
                                     + num_phys_regs + 8;

    // what the model expects back for one rob tag
    typedef struct packed {
        logic [1:0]  unit;
        logic        take;
        logic [31:0] target;
        logic [31:0] data;
        logic [5:0]  dest;
    } expect_t;

    logic                      clock;
    logic                      arst_n;
    logic                      issue_valid;
    issue_packet_t             issue_packet;
    logic [phys_reg_idx_w-1:0] rf_read_idx;
    cdb_t                      cdb;
    co_rob_packet_t            co_rob_packet;
    logic [num_fu_alu-1:0]     free_alu;
    logic [num_fu_mult-1:0]    free_mult;
    logic [num_fu_branch-1:0]  free_branch;
    logic [xlen-1:0]           rf_read_data;
    // unit order alu0, alu1, mult, branch from bit 0 up
    logic [3:0]                free_vec;

    logic [31:0] lfsr;
    logic        sweep_active;
    expect_t     expect_by_tag [32];
    int          tag_issues [32];
    int          tag_completes [32];
    int          issued_count [4];
    int          freed_count [4];
    bit [31:0]   rf_model [num_phys_regs];
    int          value_errors;
    int          protocol_errors;
    int          completed;
    int          swept;

    assign free_vec = {free_branch, free_mult, free_alu};

    backend_top #(
        .num_fu_alu      (num_fu_alu),
        .num_mult_stages (num_mult_stages)
    ) DUT (
        .clock         (clock),
        .arst_n        (arst_n),
        .issue_valid   (issue_valid),
        .issue_packet  (issue_packet),
        .rf_read_idx   (rf_read_idx),
        .cdb           (cdb),
        .co_rob_packet (co_rob_packet),
        .free_alu      (free_alu),
        .free_mult     (free_mult),
        .free_branch   (free_branch),
        .rf_read_data  (rf_read_data)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic fu_class_e class_of(input logic [1:0] unit);
        if (unit == 2'd2) begin
            return fu_mult;
        end
        if (unit == 2'd3) begin
            return fu_branch;
        end
        return fu_alu;
    endfunction

    function automatic logic [31:0] alu_model(input alu_func_e f, input logic [31:0] a,
                                              input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [4:0]         sh;
        sa = a;
        sb = b;
        sh = b[4:0];
        case (f)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << sh;
            alu_srl:  return a >> sh;
            alu_sra:  return sa >>> sh;
            alu_slt:  return (sa < sb) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            default:  return 32'd0;
        endcase
    endfunction

    function automatic logic branch_model(input br_func_e f, input logic [31:0] a,
                                          input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (f)
            br_beq:  return a == b;
            br_bne:  return a != b;
            br_blt:  return sa < sb;
            br_bge:  return !(sa < sb);
            br_bltu: return a < b;
            br_bgeu: return !(a < b);
            default: return 1'b1;
        endcase
    endfunction

    function automatic issue_packet_t random_instr(input logic [1:0] unit, input logic [4:0] tag);
        issue_packet_t p;
        logic [31:0]   r;
        p           = '0;
        p.valid     = 1'b1;
        p.rob_index = tag;
        r           = take_bits(30);
        p.pc        = {r[29:0], 2'b00};
        p.rs1_value = take_bits(32);
        // a quarter of the time equal operands, so beq and bge see ties
        r = take_bits(2);
        if (r[1:0] == 2'd0) begin
            p.rs2_value = p.rs1_value;
        end else begin
            p.rs2_value = take_bits(32);
        end
        r     = take_bits(12);
        p.imm = {{20{r[11]}}, r[11:1], 1'b0};
        // one in eight goes to the zero register
        r = take_bits(3);
        if (r[2:0] == 3'd0) begin
            p.dest_reg_idx = zero_reg;
        end else begin
            r              = take_bits(6);
            p.dest_reg_idx = r[5:0];
        end
        p.fu_class = class_of(unit);
        p.fu_index = (unit == 2'd1) ? 1'b1 : 1'b0;
        if (unit == 2'd3) begin
            r         = take_bits(3);
            p.br_func = (r[2:0] == 3'd7) ? br_jal : br_func_e'(r[2:0]);
        end else if (unit != 2'd2) begin
            r          = take_bits(4);
            p.alu_func = alu_func_e'((r[3:0] > 4'd9) ? r[3:0] - 4'd10 : r[3:0]);
        end
        return p;
    endfunction

    function automatic expect_t expect_of(input issue_packet_t p, input logic [1:0] unit);
        expect_t e;
        e      = '0;
        e.unit = unit;
        e.dest = p.dest_reg_idx;
        if (unit == 2'd2) begin
            e.data = p.rs1_value * p.rs2_value;
        end else if (unit == 2'd3) begin
            e.take   = branch_model(p.br_func, p.rs1_value, p.rs2_value);
            e.target = p.pc + p.imm;
            // taken writes the link, otherwise the result field, i.e. the target
            e.data   = e.take ? p.pc + 32'd4 : e.target;
        end else begin
            e.data = alu_model(p.alu_func, p.rs1_value, p.rs2_value);
        end
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("[ERROR] %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    // outputs sampled mid-cycle, away from the edge that moves ex_co_reg
    always @(negedge clock) begin : monitor
        expect_t    e;
        logic [4:0] tag;
        logic [3:0] exp_free;
        if (arst_n) begin
            if (co_rob_packet.valid) begin
                tag      = co_rob_packet.rob_index;
                e        = expect_by_tag[tag];
                exp_free = 4'b0001 << e.unit;
                assert (tag_issues[tag] != tag_completes[tag]) else begin
                    protocol_errors++;
                    $display("[ERROR] %0t ns: rob index %0d completed with nothing outstanding",
                             $time, tag);
                end
                // each unit the dut pulses free must have work outstanding
                for (int u = 0; u < 4; u++) begin
                    if (free_vec[u]) begin
                        assert (issued_count[u] != freed_count[u]) else begin
                            protocol_errors++;
                            $display("[ERROR] %0t ns: unit %0d freed while idle", $time, u);
                        end
                        freed_count[u]++;
                    end
                end
                check_value("free vector", 32'(free_vec), 32'(exp_free));
                check_value("co_rob_packet.fu_class", 32'(co_rob_packet.fu_class),
                            32'(class_of(e.unit)));
                check_value("co_rob_packet.take_branch", 32'(co_rob_packet.take_branch),
                            32'(e.take));
                if (e.unit == 2'd3) begin
                    check_value("co_rob_packet.branch_target", co_rob_packet.branch_target,
                                e.target);
                end
                check_value("cdb.en", 32'(cdb.en), 32'(e.dest != zero_reg));
                if (e.dest != zero_reg) begin
                    check_value("cdb.idx", 32'(cdb.idx), 32'(e.dest));
                    check_value("cdb.data", cdb.data, e.data);
                    rf_model[e.dest] = e.data;
                end
                tag_completes[tag]++;
                completed++;
            end else begin
                // nothing may fire in an idle cycle
                check_value("free vector", 32'(free_vec), 32'd0);
                check_value("cdb.en", 32'(cdb.en), 32'd0);
            end
            if (sweep_active) begin
                check_value("rf_read_data", rf_read_data,
                            (rf_read_idx == zero_reg) ? 32'd0 : rf_model[rf_read_idx]);
                swept++;
            end
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clock);
        $display("[ERROR] watchdog expired with %0d of %0d instructions completed",
                 completed, num_instr);
        $display("errors: %0d value, %0d protocol; completed %0d of %0d, swept %0d registers",
                 value_errors, protocol_errors, completed, num_instr, swept);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : driver
        issue_packet_t pkt;
        logic [31:0]   r;
        logic [1:0]    unit;
        logic [4:0]    next_tag;
        int            issued;
        lfsr         = 32'h4bca_75c4;
        arst_n       = 1'b0;
        issue_valid  = 1'b0;
        issue_packet = '0;
        rf_read_idx  = '0;
        sweep_active = 1'b0;
        next_tag     = '0;
        issued       = 0;
        repeat (reset_cycles) @(posedge clock);
        arst_n <= 1'b1;

        while (issued < num_instr) begin
            @(posedge clock);
            r    = take_bits(2);
            unit = r[1:0];
            // at most four in flight, so a free tag is always near
            while (tag_issues[next_tag] != tag_completes[next_tag]) begin
                next_tag = next_tag + 5'd1;
            end
            if (issued_count[unit] == freed_count[unit]) begin
                pkt                     = random_instr(unit, next_tag);
                expect_by_tag[next_tag] = expect_of(pkt, unit);
                tag_issues[next_tag]++;
                issued_count[unit]++;
                issued++;
                next_tag = next_tag + 5'd1;
                issue_valid  <= 1'b1;
                issue_packet <= pkt;
            end else begin
                // chosen unit still busy so this cycle stays empty
                issue_valid        <= 1'b0;
                issue_packet.valid <= 1'b0;
            end
        end
        @(posedge clock);
        issue_valid  <= 1'b0;
        issue_packet <= '0;

        while (completed < num_instr) @(posedge clock);

        // read back every register once the last write has landed
        for (int i = 0; i < num_phys_regs; i++) begin
            @(posedge clock);
            sweep_active <= 1'b1;
            rf_read_idx  <= phys_reg_idx_w'(i);
        end
        @(posedge clock);
        sweep_active <= 1'b0;
        @(posedge clock);

        $display("errors: %0d value, %0d protocol; completed %0d of %0d, swept %0d registers",
                 value_errors, protocol_errors, completed, num_instr, swept);
        if (value_errors == 0 && protocol_errors == 0 && completed == num_instr
            && swept == num_phys_regs) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
verilog/backend_pkg.sv
verilog/alu_unit.sv
verilog/branch_unit.sv
verilog/mult_unit.sv
verilog/execute_stage.sv
verilog/complete_stage.sv
verilog/phys_regfile.sv
verilog/backend_top.sv
test/backend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module backend_tb \
    -f all.f \
    -o backend_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/backend_sim)
sim_status=$?
echo "${sim_out}"
if [ ${sim_status} -ne 0 ]; then
    echo "simulation exited with status ${sim_status}"
    exit 1
fi

if echo "${sim_out}" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
